//--- sim/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb import lsu_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 32'h321f;
  localparam int N_WORDS      = 32;
  localparam int N_SUB        = 8;
  localparam int N_UART       = 6;
  localparam int N_BAD        = 3;
  localparam int N_TXN        = 2*N_WORDS + 8*N_SUB + (N_UART + 2) + (2*N_BAD + 3);
  localparam int CYCLE_LIMIT  = 40*N_TXN + RESET_CYCLES;
  localparam addr_t BAD_ADDR [N_BAD] = '{32'h0000_0100, 32'h8000_0400, 32'h1000_1000};

  logic     clock;
  logic     reset;
  logic     ren;
  logic     wen;
  lsu_req_t req;
  word_t    load_data;
  logic     read_done;
  logic     write_done;
  logic     bus_error;
  byte      uart_byte;
  logic     uart_strobe;

  logic [7:0] shadow [MEM_WORDS*4]; // byte image of the data memory.
  int         uart_count;
  int         strobe_total;
  int         cycles = 0;
  int         value_errs;
  int         proto_errs;
  int         txn_count;
  string      test_name;
  word_t      exp_data;
  logic       exp_err;
  byte        exp_byte;
  logic       started;
  logic       pending;
  logic       pend_write;

  mem_subsys_top mem_subsys_top_i (
    .clock       (clock),
    .reset       (reset),
    .ren         (ren),
    .wen         (wen),
    .req         (req),
    .load_data   (load_data),
    .read_done   (read_done),
    .write_done  (write_done),
    .bus_error   (bus_error),
    .uart_byte   (uart_byte),
    .uart_strobe (uart_strobe)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD/2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a transaction never completed", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  always @(posedge clock) begin
    if (reset)
      strobe_total <= 0;
    else if (uart_strobe)
      strobe_total <= strobe_total + 1;
  end

  function automatic logic in_mem(addr_t a);
    return a >= MEM_BASE && a < MEM_BASE + addr_t'(MEM_WORDS * 4);
  endfunction

  function automatic logic in_uart(addr_t a);
    return a[31:12] == UART_BASE[31:12];
  endfunction

  // expected load result, built byte by byte from the shadow image.
  function automatic word_t load_model(addr_t a, size_t size, logic sext);
    word_t v;
    int    n;
    n = (size == SIZE_B) ? 1 : (size == SIZE_H) ? 2 : 4;
    v = '0;
    if (in_mem(a)) begin
      for (int i = 0; i < n; i++)
        v[8*i +: 8] = shadow[int'(a - MEM_BASE) + i];
    end else if (in_uart(a) && a[11:0] == 12'h004) begin
      v = word_t'(uart_count & 255);
    end
    if (sext && n < 4 && v[8*n-1])
      v = v | (32'hffff_ffff << (8*n));
    return v;
  endfunction

  task automatic run_txn(input logic is_write, input lsu_req_t r);
    req        = r;
    ren        = !is_write;
    wen        = is_write;
    started    = 1'b1;
    pending    = 1'b1;
    pend_write = is_write;
    txn_count++;
    @(posedge clock);
    #1;
    ren = 1'b0;
    wen = 1'b0;
    do begin
      @(posedge clock);
      #1;
    end while (!(read_done || write_done));
    @(posedge clock); // unit is back in idle after this edge.
    #1;
    pending = 1'b0;
  endtask

  task automatic do_store(input addr_t a, input word_t data, input size_t size);
    lsu_req_t r;
    int       n;
    r.addr  = a;
    r.wsrc  = data;
    r.size  = size;
    r.sext  = 1'b0;
    n       = (size == SIZE_B) ? 1 : (size == SIZE_H) ? 2 : 4;
    exp_err = !(in_mem(a) || in_uart(a));
    if (in_mem(a)) begin
      for (int i = 0; i < n; i++)
        shadow[int'(a - MEM_BASE) + i] = data[8*i +: 8];
    end else if (in_uart(a) && a[11:0] == 12'h000) begin
      uart_count++;
      exp_byte = data[7:0];
    end
    run_txn(1'b1, r);
  endtask

  task automatic do_load(input addr_t a, input size_t size, input logic sext);
    lsu_req_t r;
    r.addr   = a;
    r.wsrc   = '0;
    r.size   = size;
    r.sext   = sext;
    exp_data = load_model(a, size, sext);
    exp_err  = !(in_mem(a) || in_uart(a));
    run_txn(1'b0, r);
  endtask

  a_load_value: assert property (@(posedge clock) disable iff (reset)
    read_done |-> load_data == exp_data)
    else begin
      value_errs++;
      $display("ERR %s: load_data expected %h actual %h", test_name, exp_data,
               $sampled(load_data));
    end

  a_error_flag: assert property (@(posedge clock) disable iff (reset)
    (read_done || write_done) |-> bus_error == exp_err)
    else begin
      value_errs++;
      $display("ERR %s: bus_error expected %b actual %b", test_name, exp_err,
               $sampled(bus_error));
    end

  a_strobe_byte: assert property (@(posedge clock) disable iff (reset)
    uart_strobe |-> uart_byte == exp_byte)
    else begin
      value_errs++;
      $display("ERR %s: uart_byte expected %h actual %h", test_name, exp_byte,
               $sampled(uart_byte));
    end

  // every UART data store gives one strobe before its write_done.
  a_strobe_count: assert property (@(posedge clock) disable iff (reset)
    (read_done || write_done) |-> strobe_total == uart_count)
    else begin
      value_errs++;
      $display("ERR %s: strobe count expected %0d actual %0d", test_name, uart_count,
               $sampled(strobe_total));
    end

  a_done_single: assert property (@(posedge clock) disable iff (reset)
    (read_done || write_done) |=> !(read_done || write_done))
    else begin
      proto_errs++;
      $display("%s: a done pulse lasted more than one cycle", test_name);
    end

  a_read_done_req: assert property (@(posedge clock) disable iff (reset)
    read_done |-> pending && !pend_write)
    else begin
      proto_errs++;
      $display("%s: read_done came without a pending load", test_name);
    end

  a_write_done_req: assert property (@(posedge clock) disable iff (reset)
    write_done |-> pending && pend_write)
    else begin
      proto_errs++;
      $display("%s: write_done came without a pending store", test_name);
    end

  a_quiet: assert property (@(posedge clock) disable iff (reset)
    !started |-> !(read_done || write_done || uart_strobe
      || mem_subsys_top_i.lsu_m2s.arvalid || mem_subsys_top_i.lsu_m2s.awvalid
      || mem_subsys_top_i.lsu_m2s.wvalid
      || mem_subsys_top_i.mem_s2m.rvalid || mem_subsys_top_i.mem_s2m.bvalid
      || mem_subsys_top_i.uart_s2m.rvalid || mem_subsys_top_i.uart_s2m.bvalid))
    else begin
      proto_errs++;
      $display("%s: activity seen after reset before the first request", test_name);
    end

  initial begin
    addr_t       a;
    word_t       data;
    int unsigned seed_dummy;
    reset      = 1'b1;
    ren        = 1'b0;
    wen        = 1'b0;
    req        = '0;
    started    = 1'b0;
    pending    = 1'b0;
    pend_write = 1'b0;
    exp_data   = '0;
    exp_err    = 1'b0;
    exp_byte   = 8'h00;
    uart_count = 0;
    value_errs = 0;
    proto_errs = 0;
    txn_count  = 0;
    test_name  = "reset";
    seed_dummy = $urandom(SEED);
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (4) @(posedge clock); // idle window after reset.
    #1;

    test_name = "word_rw";
    for (int i = 0; i < N_WORDS; i++)
      do_store(MEM_BASE + addr_t'(4*i), $urandom, SIZE_W);
    for (int i = 0; i < N_WORDS; i++)
      do_load(MEM_BASE + addr_t'(4*i), SIZE_W, 1'b0);

    test_name = "byte_half";
    for (int k = 0; k < N_SUB; k++) begin
      a       = MEM_BASE + addr_t'(4*k + k % 4);
      data    = $urandom;
      data[7] = k[2]; // both signs at each lane offset.
      do_store(a, data, SIZE_B);
      do_load(a, SIZE_B, 1'b0);
      do_load(a, SIZE_B, 1'b1);
      do_load(MEM_BASE + addr_t'(4*k), SIZE_W, 1'b0);
    end
    for (int k = 0; k < N_SUB; k++) begin
      a        = MEM_BASE + addr_t'(4*(N_SUB + k) + 2*(k % 2));
      data     = $urandom;
      data[15] = k[1];
      do_store(a, data, SIZE_H);
      do_load(a, SIZE_H, 1'b0);
      do_load(a, SIZE_H, 1'b1);
      do_load(MEM_BASE + addr_t'(4*(N_SUB + k)), SIZE_W, 1'b0);
    end

    test_name = "uart";
    do_load(UART_BASE + 32'h4, SIZE_W, 1'b0);
    for (int k = 0; k < N_UART; k++)
      do_store(UART_BASE, $urandom, k[0] ? SIZE_W : SIZE_B);
    do_load(UART_BASE + 32'h4, SIZE_W, 1'b0);

    test_name = "unmapped";
    for (int k = 0; k < N_BAD; k++) begin
      do_load(BAD_ADDR[k], SIZE_W, 1'b0);
      do_store(BAD_ADDR[k], $urandom, SIZE_W);
    end
    do_load(MEM_BASE, SIZE_W, 1'b0);
    do_load(MEM_BASE + addr_t'(4*(N_WORDS - 1)), SIZE_W, 1'b0);
    do_load(UART_BASE + 32'h4, SIZE_W, 1'b0);

    repeat (2) @(posedge clock);
    #1;
    $display("errors: value %0d, protocol %0d over %0d transactions",
             value_errs, proto_errs, txn_count);
    if (value_errs == 0 && proto_errs == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- source/bus_xbar.sv
`timescale 1ns/1ps

module bus_xbar import lsu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_m2s_t m_m2s,
  output axi_s2m_t m_s2m,
  output axi_m2s_t mem_m2s,
  input  axi_s2m_t mem_s2m,
  output axi_m2s_t uart_m2s,
  input  axi_s2m_t uart_s2m
);

  typedef enum logic [1:0] {TGT_NONE, TGT_MEM, TGT_UART} tgt_t;

  tgt_t     tgt_q;
  tgt_t     dec_tgt;
  tgt_t     sel;
  logic     active;
  logic     addr_hs;
  logic     resp_hs;
  logic     de_rvalid;
  logic     de_bvalid;
  addr_t    dec_addr;
  axi_s2m_t de_s2m;

  function automatic tgt_t decode(addr_t a);
    if (a[31:12] == UART_BASE[31:12])
      return TGT_UART;
    if (a >= MEM_BASE && a < MEM_LIMIT)
      return TGT_MEM;
    return TGT_NONE;
  endfunction

  function automatic axi_m2s_t gate(axi_m2s_t m, logic en);
    axi_m2s_t g;
    g         = m;
    g.arvalid = m.arvalid && en;
    g.rready  = m.rready && en;
    g.awvalid = m.awvalid && en;
    g.wvalid  = m.wvalid && en;
    g.bready  = m.bready && en;
    return g;
  endfunction

  assign dec_addr = m_m2s.arvalid ? m_m2s.araddr : m_m2s.awaddr;
  assign dec_tgt  = decode(dec_addr);
  assign sel      = active ? tgt_q : dec_tgt; // latched after the address transfer.

  assign mem_m2s  = gate(m_m2s, sel == TGT_MEM);
  assign uart_m2s = gate(m_m2s, sel == TGT_UART);

  always_comb begin
    de_s2m         = '0;
    de_s2m.arready = !active;
    de_s2m.awready = !active;
    de_s2m.wready  = active && !de_bvalid;
    de_s2m.rvalid  = de_rvalid;
    de_s2m.rresp   = RESP_DECERR;
    de_s2m.bvalid  = de_bvalid;
    de_s2m.bresp   = RESP_DECERR;
    case (sel)
      TGT_MEM:  m_s2m = mem_s2m;
      TGT_UART: m_s2m = uart_s2m;
      default:  m_s2m = de_s2m;
    endcase
  end

  assign addr_hs = (m_m2s.arvalid && m_s2m.arready) || (m_m2s.awvalid && m_s2m.awready);
  assign resp_hs = (m_s2m.rvalid && m_m2s.rready) || (m_s2m.bvalid && m_m2s.bready);

  always_ff @(posedge clock) begin
    if (reset) begin
      active    <= 1'b0;
      tgt_q     <= TGT_NONE;
      de_rvalid <= 1'b0;
      de_bvalid <= 1'b0;
    end else begin
      if (!active && addr_hs) begin
        active <= 1'b1;
        tgt_q  <= dec_tgt;
      end else if (active && resp_hs) begin
        active <= 1'b0;
      end
      if (sel == TGT_NONE && !active && m_m2s.arvalid)
        de_rvalid <= 1'b1;
      else if (de_rvalid && m_m2s.rready)
        de_rvalid <= 1'b0;
      if (sel == TGT_NONE && active && m_m2s.wvalid && !de_bvalid)
        de_bvalid <= 1'b1;
      else if (de_bvalid && m_m2s.bready)
        de_bvalid <= 1'b0;
    end
  end

  a_one_slave_resp: assert property (@(posedge clock) disable iff (reset)
    !((mem_s2m.rvalid || mem_s2m.bvalid) && (uart_s2m.rvalid || uart_s2m.bvalid)));

endmodule

//--- source/data_mem.sv
`timescale 1ns/1ps

module data_mem import lsu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_m2s_t m2s,
  output axi_s2m_t s2m
);

  word_t                mem [MEM_WORDS];
  word_t                rdata_q;
  logic [MEM_IDX_W-1:0] aw_idx;
  logic                 arready_q;
  logic                 awready_q;
  logic                 wready_q;
  logic                 rvalid_q;
  logic                 bvalid_q;
  logic                 aw_acc;
  logic                 ar_hs;
  logic                 aw_hs;
  logic                 w_hs;

  assign ar_hs = m2s.arvalid && arready_q;
  assign aw_hs = m2s.awvalid && awready_q;
  assign w_hs  = m2s.wvalid && wready_q;

  always_comb begin
    s2m.arready = arready_q;
    s2m.rdata   = rdata_q;
    s2m.rresp   = RESP_OKAY;
    s2m.rvalid  = rvalid_q;
    s2m.awready = awready_q;
    s2m.wready  = wready_q;
    s2m.bresp   = RESP_OKAY;
    s2m.bvalid  = bvalid_q;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      arready_q <= 1'b0;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      aw_acc    <= 1'b0;
    end else begin
      arready_q <= m2s.arvalid && !arready_q && !rvalid_q; // one-cycle ready.
      awready_q <= m2s.awvalid && !awready_q && !aw_acc && !bvalid_q;
      wready_q  <= m2s.wvalid && aw_acc && !wready_q;
      if (ar_hs)
        rvalid_q <= 1'b1;
      else if (rvalid_q && m2s.rready)
        rvalid_q <= 1'b0;
      if (aw_hs)
        aw_acc <= 1'b1;
      else if (w_hs)
        aw_acc <= 1'b0;
      if (w_hs)
        bvalid_q <= 1'b1;
      else if (bvalid_q && m2s.bready)
        bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_hs)
      rdata_q <= mem[m2s.araddr[MEM_IDX_W+1:2]];
    if (aw_hs)
      aw_idx <= m2s.awaddr[MEM_IDX_W+1:2];
    if (w_hs) begin
      for (int i = 0; i < 4; i++) begin
        if (m2s.wstrb[i])
          mem[aw_idx][8*i +: 8] <= m2s.wdata[8*i +: 8]; // strobed bytes only.
      end
    end
  end

endmodule

//--- source/lsu_core.sv
`timescale 1ns/1ps

module lsu_core import lsu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     ren,
  input  logic     wen,
  input  lsu_req_t req,
  output word_t    load_data,
  output logic     read_done,
  output logic     write_done,
  output logic     bus_error,
  output axi_m2s_t m2s,
  input  axi_s2m_t s2m
);

  typedef enum logic [2:0] {
    IDLE,
    RADDR,
    RDATA,
    WADDR,
    WDATA,
    BRESP,
    DONE
  } lsu_state_t;

  lsu_state_t state;
  logic [4:0] lane_shift;
  word_t      rd_shifted;
  word_t      rd_ext;
  strb_t      st_strb;

  assign lane_shift = {req.addr[1:0], 3'b000}; // byte offset in bits.

  always_comb begin
    case (req.size)
      SIZE_B:  st_strb = 4'b0001 << req.addr[1:0];
      SIZE_H:  st_strb = 4'b0011 << req.addr[1:0];
      default: st_strb = 4'b1111;
    endcase
  end

  // bring the addressed lane down to bit 0, then extend.
  always_comb begin
    rd_shifted = s2m.rdata >> lane_shift;
    case (req.size)
      SIZE_B:  rd_ext = req.sext ? {{24{rd_shifted[7]}}, rd_shifted[7:0]}
                                 : {24'b0, rd_shifted[7:0]};
      SIZE_H:  rd_ext = req.sext ? {{16{rd_shifted[15]}}, rd_shifted[15:0]}
                                 : {16'b0, rd_shifted[15:0]};
      SIZE_W:  rd_ext = rd_shifted;
      default: rd_ext = rd_shifted;
    endcase
  end

  always_comb begin
    m2s.araddr  = req.addr;
    m2s.arvalid = (state == RADDR);
    m2s.rready  = (state == RDATA);
    m2s.awaddr  = req.addr;
    m2s.awvalid = (state == WADDR);
    m2s.wdata   = req.wsrc << lane_shift;
    m2s.wstrb   = st_strb;
    m2s.wvalid  = (state == WDATA);
    m2s.bready  = (state == BRESP);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= IDLE;
      read_done  <= 1'b0;
      write_done <= 1'b0;
      bus_error  <= 1'b0;
    end else begin
      read_done  <= 1'b0;
      write_done <= 1'b0;
      case (state)
        IDLE: begin
          if (ren)
            state <= RADDR;
          else if (wen)
            state <= WADDR;
        end
        RADDR: if (s2m.arready) state <= RDATA;
        RDATA: begin
          if (s2m.rvalid) begin
            state     <= DONE;
            read_done <= 1'b1;
            bus_error <= (s2m.rresp != RESP_OKAY);
          end
        end
        WADDR: if (s2m.awready) state <= WDATA;
        WDATA: if (s2m.wready) state <= BRESP;
        BRESP: begin
          if (s2m.bvalid) begin
            state      <= DONE;
            write_done <= 1'b1;
            bus_error  <= (s2m.bresp != RESP_OKAY);
          end
        end
        default: state <= IDLE; // done pulse is out, back to idle.
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == RDATA && s2m.rvalid)
      load_data <= rd_ext;
  end

  a_no_rw_overlap: assert property (@(posedge clock) disable iff (reset)
    !(ren && wen));

  a_half_aligned: assert property (@(posedge clock) disable iff (reset)
    (ren || wen) && req.size == SIZE_H |-> !req.addr[0]);

  a_word_aligned: assert property (@(posedge clock) disable iff (reset)
    (ren || wen) && req.size == SIZE_W |-> req.addr[1:0] == 2'b00);

  a_arvalid_hold: assert property (@(posedge clock) disable iff (reset)
    m2s.arvalid && !s2m.arready |=> m2s.arvalid && $stable(m2s.araddr));

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [1:0]  size_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  localparam size_t SIZE_B = 2'd0;
  localparam size_t SIZE_H = 2'd1;
  localparam size_t SIZE_W = 2'd2;

  localparam addr_t MEM_BASE  = 32'h8000_0000;
  localparam int    MEM_WORDS = 256;
  localparam int    MEM_IDX_W = $clog2(MEM_WORDS);
  localparam addr_t MEM_LIMIT = MEM_BASE + addr_t'(MEM_WORDS * 4); // first address past memory.

  localparam addr_t       UART_BASE     = 32'h1000_0000; // 4 KiB window.
  localparam logic [11:0] UART_TXD_OFS  = 12'h000;
  localparam logic [11:0] UART_STAT_OFS = 12'h004;

  typedef struct packed {
    addr_t addr;
    word_t wsrc;
    size_t size;
    logic  sext;
  } lsu_req_t;

  // master to slave half of the AXI-lite port
  typedef struct packed {
    addr_t araddr;
    logic  arvalid;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    word_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  bready;
  } axi_m2s_t;

  typedef struct packed {
    logic  arready;
    word_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  awready;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
  } axi_s2m_t;

endpackage

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top import lsu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     ren,
  input  logic     wen,
  input  lsu_req_t req,
  output word_t    load_data,
  output logic     read_done,
  output logic     write_done,
  output logic     bus_error,
  output byte      uart_byte,
  output logic     uart_strobe
);

  axi_m2s_t lsu_m2s;
  axi_s2m_t lsu_s2m;
  axi_m2s_t mem_m2s;
  axi_s2m_t mem_s2m;
  axi_m2s_t uart_m2s;
  axi_s2m_t uart_s2m;

  lsu_core lsu_core_i (
    .clock      (clock),
    .reset      (reset),
    .ren        (ren),
    .wen        (wen),
    .req        (req),
    .load_data  (load_data),
    .read_done  (read_done),
    .write_done (write_done),
    .bus_error  (bus_error),
    .m2s        (lsu_m2s),
    .s2m        (lsu_s2m)
  );

  bus_xbar bus_xbar_i (
    .clock    (clock),
    .reset    (reset),
    .m_m2s    (lsu_m2s),
    .m_s2m    (lsu_s2m),
    .mem_m2s  (mem_m2s),
    .mem_s2m  (mem_s2m),
    .uart_m2s (uart_m2s),
    .uart_s2m (uart_s2m)
  );

  data_mem data_mem_i (
    .clock (clock),
    .reset (reset),
    .m2s   (mem_m2s),
    .s2m   (mem_s2m)
  );

  uart_tx_dev uart_tx_dev_i (
    .clock       (clock),
    .reset       (reset),
    .m2s         (uart_m2s),
    .s2m         (uart_s2m),
    .uart_byte   (uart_byte),
    .uart_strobe (uart_strobe)
  );

endmodule

//--- source/uart_tx_dev.sv
`timescale 1ns/1ps

module uart_tx_dev import lsu_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  axi_m2s_t m2s,
  output axi_s2m_t s2m,
  output byte      uart_byte,
  output logic     uart_strobe
);

  word_t       rdata_q;
  logic [11:0] aw_ofs;
  logic [7:0]  sent_cnt;
  logic        arready_q;
  logic        awready_q;
  logic        wready_q;
  logic        rvalid_q;
  logic        bvalid_q;
  logic        aw_acc;
  logic        ar_hs;
  logic        aw_hs;
  logic        w_hs;
  logic        tx_wr;

  // lowest strobed lane wins.
  function automatic byte lane_byte(word_t d, strb_t s);
    if (s[0])
      return d[7:0];
    if (s[1])
      return d[15:8];
    if (s[2])
      return d[23:16];
    return d[31:24];
  endfunction

  assign ar_hs = m2s.arvalid && arready_q;
  assign aw_hs = m2s.awvalid && awready_q;
  assign w_hs  = m2s.wvalid && wready_q;
  assign tx_wr = w_hs && (aw_ofs == UART_TXD_OFS);

  always_comb begin
    s2m.arready = arready_q;
    s2m.rdata   = rdata_q;
    s2m.rresp   = RESP_OKAY;
    s2m.rvalid  = rvalid_q;
    s2m.awready = awready_q;
    s2m.wready  = wready_q;
    s2m.bresp   = RESP_OKAY;
    s2m.bvalid  = bvalid_q;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      arready_q   <= 1'b0;
      awready_q   <= 1'b0;
      wready_q    <= 1'b0;
      rvalid_q    <= 1'b0;
      bvalid_q    <= 1'b0;
      aw_acc      <= 1'b0;
      uart_strobe <= 1'b0;
      sent_cnt    <= 8'd0;
    end else begin
      arready_q   <= m2s.arvalid && !arready_q && !rvalid_q;
      awready_q   <= m2s.awvalid && !awready_q && !aw_acc && !bvalid_q;
      wready_q    <= m2s.wvalid && aw_acc && !wready_q;
      uart_strobe <= tx_wr;
      if (tx_wr)
        sent_cnt <= sent_cnt + 8'd1;
      if (ar_hs)
        rvalid_q <= 1'b1;
      else if (rvalid_q && m2s.rready)
        rvalid_q <= 1'b0;
      if (aw_hs)
        aw_acc <= 1'b1;
      else if (w_hs)
        aw_acc <= 1'b0;
      if (w_hs)
        bvalid_q <= 1'b1;
      else if (bvalid_q && m2s.bready)
        bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_hs)
      rdata_q <= (m2s.araddr[11:0] == UART_STAT_OFS) ? word_t'(sent_cnt) : '0;
    if (aw_hs)
      aw_ofs <= m2s.awaddr[11:0];
    if (tx_wr)
      uart_byte <= lane_byte(m2s.wdata, m2s.wstrb);
  end

endmodule

//--- src.f
source/lsu_pkg.sv
source/lsu_core.sv
source/bus_xbar.sv
source/data_mem.sv
source/uart_tx_dev.sv
source/mem_subsys_top.sv
sim/mem_subsys_tb.sv
